//--- src/numbat_ctrl_pkg.sv
//**********************************************************
// Widths, register map and packed types shared by the host
// register block and the engine side of the chess searcher.
//**********************************************************

package numbat_ctrl_pkg;

   localparam int BOARD_WIDTH       = 256;
   localparam int CTRL_DATA_WIDTH   = 128;
   localparam int CTRL_STROBE_WIDTH = 16;
   localparam int CTRL_ADDR_WIDTH   = 18;
   localparam int REG_INDEX_WIDTH   = 14; // byte address without low 4 bits
   localparam int EVAL_WIDTH        = 24;
   localparam int MOVE_INDEX_WIDTH  = 7;
   localparam int HALF_MOVE_WIDTH   = 7;
   localparam int UCI_WIDTH         = 16;

   localparam logic [REG_INDEX_WIDTH-1:0] REG_CONTROL       = 14'd0;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_INDEX    = 14'd1;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_POSITION      = 14'd2;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_HALF_MOVE     = 14'd3;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_QUIESCENCE    = 14'd4;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BOARD_LO      = 14'd8;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BOARD_HI      = 14'd9;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_POSITION = 14'd133;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_EVAL     = 14'd134;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_COUNT    = 14'd135;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_ROOT_EVAL     = 14'd136;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_UCI      = 14'd139;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_TRANS_STATUS  = 14'd512;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_TRANS_EVAL    = 14'd514;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_TRANS_CMD     = 14'd520;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_TRANS_ARG     = 14'd521;

   typedef logic [BOARD_WIDTH-1:0] board_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   // board words use the byte lanes, every other register the low word
   typedef union packed {
      logic [CTRL_STROBE_WIDTH-1:0][7:0] lanes;
      struct packed {
         logic [CTRL_DATA_WIDTH-33:0] upper;
         logic [31:0]                 word;
      } reg32;
   } ctrl_word_t;

   typedef struct packed {
      logic                         en;
      logic [CTRL_STROBE_WIDTH-1:0] we;
      logic [CTRL_ADDR_WIDTH-1:0]   addr;
      ctrl_word_t                   din;
   } ctrl_req_t;

   typedef struct packed {
      logic                        new_board_valid;
      logic                        clear_moves;
      logic                        quiescence;
      logic                        soft_reset;
      logic [MOVE_INDEX_WIDTH-1:0] move_index;
      logic [HALF_MOVE_WIDTH-1:0]  half_move;
      position_t                   position;
   } search_cmd_t;

   typedef struct packed {
      logic [7:0]                   depth;
      logic                         clear;
      logic                         hash_only;
      logic [1:0]                   flag;
      logic                         store;
      logic                         lookup;
      logic                         capture;
      logic signed [EVAL_WIDTH-1:0] eval;
   } trans_cmd_t;

   typedef struct packed {
      logic                         capture;
      logic                         collision;
      logic [7:0]                   depth;
      logic [1:0]                   flag;
      logic                         entry_valid;
      logic                         idle;
      logic signed [EVAL_WIDTH-1:0] eval;
   } trans_status_t;

   typedef struct packed {
      logic                         mate;
      logic                         stalemate;
      logic                         thrice_rep;
      logic                         fifty_move;
      logic                         insufficient;
      logic                         check;
      logic signed [EVAL_WIDTH-1:0] eval; // root node eval
   } root_status_t;

   typedef struct packed {
      logic                         idle;
      logic                         moves_ready; // all moves generated
      logic                         move_ready;  // indexed move valid
      logic [MOVE_INDEX_WIDTH-1:0]  move_count;
      logic signed [EVAL_WIDTH-1:0] eval;
      logic [UCI_WIDTH-1:0]         uci;
      position_t                    position;
   } movegen_status_t;

endpackage

//--- src/board_load_regs.sv
//**********************************************************
// Holds the 256-bit board, loaded as two byte-strobed words.
//**********************************************************
`timescale 1ns/1ps

module board_load_regs
  (
   input  logic                                            clk,
   input  logic                                            reset,
   input  logic                                            lo_wr,
   input  logic                                            hi_wr,
   input  logic [numbat_ctrl_pkg::CTRL_STROBE_WIDTH-1:0]   we,
   input  numbat_ctrl_pkg::ctrl_word_t                     din,
   output numbat_ctrl_pkg::board_t                         board
   );

   import numbat_ctrl_pkg::*;

   always_ff @(posedge clk)
   begin
      if (reset)
         board <= '0;
      else if (lo_wr || hi_wr)
      begin
         for (int lane = 0; lane < CTRL_STROBE_WIDTH; lane++)
         begin
            if (we[lane])
            begin
               if (hi_wr)
                  board[CTRL_DATA_WIDTH + lane * 8 +: 8] <= din.lanes[lane]; // upper half
               else
                  board[lane * 8 +: 8] <= din.lanes[lane];
            end
         end
      end
   end

endmodule

//--- src/search_ctrl_regs.sv
//**********************************************************
// Host-writable search and transposition table commands,
// updated from the low 32-bit view of a register write.
//**********************************************************
`timescale 1ns/1ps

module search_ctrl_regs
  (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic                                          reg_wr,
   input  logic [numbat_ctrl_pkg::REG_INDEX_WIDTH-1:0]   reg_index,
   input  numbat_ctrl_pkg::ctrl_word_t                   din,
   output numbat_ctrl_pkg::search_cmd_t                  search_cmd,
   output numbat_ctrl_pkg::trans_cmd_t                   trans_cmd
   );

   import numbat_ctrl_pkg::*;

   logic [31:0] word;

   assign word = din.reg32.word;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         search_cmd <= '0;
         trans_cmd  <= '0;
      end
      else if (reg_wr)
      begin
         case (reg_index)
            REG_CONTROL :
            begin
               search_cmd.new_board_valid <= word[0];
               search_cmd.clear_moves     <= word[1];
               search_cmd.soft_reset      <= word[31];
            end
            REG_MOVE_INDEX :
               search_cmd.move_index <= word[MOVE_INDEX_WIDTH-1:0];
            REG_POSITION :
               search_cmd.position <= position_t'(word[$bits(position_t)-1:0]);
            REG_HALF_MOVE :
               search_cmd.half_move <= word[HALF_MOVE_WIDTH-1:0];
            REG_QUIESCENCE :
               search_cmd.quiescence <= word[0];
            REG_TRANS_CMD :
            begin
               trans_cmd.depth     <= word[15:8];
               trans_cmd.clear     <= word[5];
               trans_cmd.hash_only <= word[4];
               trans_cmd.flag      <= word[3:2];
               trans_cmd.store     <= word[1];
               trans_cmd.lookup    <= word[0];
            end
            REG_TRANS_ARG :
            begin
               trans_cmd.capture <= word[31];
               trans_cmd.eval    <= word[EVAL_WIDTH-1:0];
            end
            default :
            begin
               // other indices belong to the board or are read only
            end
         endcase
      end
   end

endmodule

//--- src/status_read_mux.sv
//**********************************************************
// Registered host readback: formats one 32-bit word per
// index, shown on ctrl_dout one cycle after the address.
//**********************************************************
`timescale 1ns/1ps

module status_read_mux
  (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic [numbat_ctrl_pkg::REG_INDEX_WIDTH-1:0]   rd_index,
   input  numbat_ctrl_pkg::search_cmd_t                  search_cmd,
   input  numbat_ctrl_pkg::trans_cmd_t                   trans_cmd,
   input  numbat_ctrl_pkg::movegen_status_t              movegen_status,
   input  numbat_ctrl_pkg::root_status_t                 root_status,
   input  numbat_ctrl_pkg::trans_status_t                trans_status,
   output logic [numbat_ctrl_pkg::CTRL_DATA_WIDTH-1:0]   ctrl_dout
   );

   import numbat_ctrl_pkg::*;

   logic [31:0] rd_word;
   logic [31:0] dout_q;

   function automatic logic [31:0] sext_eval(input logic [EVAL_WIDTH-1:0] eval);
      return {{(32 - EVAL_WIDTH){eval[EVAL_WIDTH-1]}}, eval};
   endfunction

   always_comb
   begin
      rd_word = '0;
      case (rd_index)
         REG_CONTROL :
         begin
            rd_word[0]  = search_cmd.new_board_valid;
            rd_word[1]  = search_cmd.clear_moves;
            rd_word[2]  = movegen_status.moves_ready;
            rd_word[3]  = movegen_status.move_ready;
            rd_word[4]  = root_status.stalemate;
            rd_word[5]  = root_status.mate;
            rd_word[6]  = root_status.thrice_rep;
            rd_word[7]  = movegen_status.idle;
            rd_word[8]  = root_status.fifty_move;
            rd_word[9]  = root_status.insufficient;
            rd_word[10] = root_status.check;
            rd_word[31] = search_cmd.soft_reset;
         end
         REG_MOVE_INDEX    : rd_word = 32'(search_cmd.move_index);
         REG_POSITION      : rd_word = 32'(search_cmd.position);
         REG_HALF_MOVE     : rd_word = 32'(search_cmd.half_move);
         REG_QUIESCENCE    : rd_word = 32'(search_cmd.quiescence);
         REG_MOVE_POSITION : rd_word = 32'(movegen_status.position);
         REG_MOVE_EVAL     : rd_word = sext_eval(movegen_status.eval);
         REG_MOVE_COUNT    : rd_word = 32'(movegen_status.move_count);
         REG_ROOT_EVAL     : rd_word = sext_eval(root_status.eval);
         REG_MOVE_UCI      : // nibble spread, one gap bit per field
            rd_word = {12'b0, movegen_status.uci[15:12],
                       1'b0, movegen_status.uci[11:9],
                       1'b0, movegen_status.uci[8:6],
                       1'b0, movegen_status.uci[5:3],
                       1'b0, movegen_status.uci[2:0]};
         REG_TRANS_STATUS  :
            rd_word = {12'b0, trans_status.capture, trans_status.collision,
                       trans_status.depth, 4'b0, trans_status.flag, 2'b0,
                       trans_status.entry_valid, trans_status.idle};
         REG_TRANS_EVAL    : rd_word = sext_eval(trans_status.eval);
         REG_TRANS_CMD     :
            rd_word = {16'b0, trans_cmd.depth, 2'b0, trans_cmd.clear,
                       trans_cmd.hash_only, trans_cmd.flag,
                       trans_cmd.store, trans_cmd.lookup};
         REG_TRANS_ARG     : // eval zero extended here
            rd_word = {trans_cmd.capture, {(31 - EVAL_WIDTH){1'b0}}, trans_cmd.eval};
         default           : rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dout_q <= '0;
      else
         dout_q <= rd_word;
   end

   assign ctrl_dout = {{(CTRL_DATA_WIDTH - 32){1'b0}}, dout_q};

endmodule

//--- src/numbat_control.sv
//**********************************************************
// Host register block top: decodes the block-RAM style port
// and joins board loading, command registers and readback.
//**********************************************************
`timescale 1ns/1ps

module numbat_control
  (
   input  logic                                          clk,
   input  logic                                          reset,
   input  numbat_ctrl_pkg::ctrl_req_t                    ctrl_req,
   input  numbat_ctrl_pkg::movegen_status_t              movegen_status,
   input  numbat_ctrl_pkg::root_status_t                 root_status,
   input  numbat_ctrl_pkg::trans_status_t                trans_status,
   output logic [numbat_ctrl_pkg::CTRL_DATA_WIDTH-1:0]   ctrl_dout,
   output numbat_ctrl_pkg::board_t                       board,
   output numbat_ctrl_pkg::search_cmd_t                  search_cmd,
   output numbat_ctrl_pkg::trans_cmd_t                   trans_cmd
   );

   import numbat_ctrl_pkg::*;

   typedef struct packed {
      logic board_lo_wr;
      logic board_hi_wr;
      logic reg_wr;
   } wr_sel_t;

   logic                       wr_valid;
   logic [REG_INDEX_WIDTH-1:0] reg_index;
   wr_sel_t                    wr_sel;

   assign wr_valid  = ctrl_req.en && (ctrl_req.we != '0);
   assign reg_index = ctrl_req.addr[CTRL_ADDR_WIDTH-1:4]; // same index for reads

   assign wr_sel.board_lo_wr = wr_valid && (reg_index == REG_BOARD_LO);
   assign wr_sel.board_hi_wr = wr_valid && (reg_index == REG_BOARD_HI);
   assign wr_sel.reg_wr      = wr_valid && !wr_sel.board_lo_wr && !wr_sel.board_hi_wr;

   board_load_regs u_board_load_regs (
      .clk   (clk),
      .reset (reset),
      .lo_wr (wr_sel.board_lo_wr),
      .hi_wr (wr_sel.board_hi_wr),
      .we    (ctrl_req.we),
      .din   (ctrl_req.din),
      .board (board)
   );

   search_ctrl_regs u_search_ctrl_regs (
      .clk        (clk),
      .reset      (reset),
      .reg_wr     (wr_sel.reg_wr),
      .reg_index  (reg_index),
      .din        (ctrl_req.din),
      .search_cmd (search_cmd),
      .trans_cmd  (trans_cmd)
   );

   status_read_mux u_status_read_mux (
      .clk            (clk),
      .reset          (reset),
      .rd_index       (reg_index),
      .search_cmd     (search_cmd),
      .trans_cmd      (trans_cmd),
      .movegen_status (movegen_status),
      .root_status    (root_status),
      .trans_status   (trans_status),
      .ctrl_dout      (ctrl_dout)
   );

endmodule

//--- testbench/numbat_control_assertions.sv
//**********************************************************
// Concurrent checks on the host port, bound into the top.
//**********************************************************
`timescale 1ns/1ps

module numbat_control_assertions
  (
   input logic                                         clk,
   input logic                                         reset,
   input numbat_ctrl_pkg::ctrl_req_t                   ctrl_req,
   input logic [numbat_ctrl_pkg::CTRL_DATA_WIDTH-1:0]  ctrl_dout,
   input numbat_ctrl_pkg::board_t                      board
   );

   import numbat_ctrl_pkg::*;

   logic [REG_INDEX_WIDTH-1:0] rd_index;
   logic                       unknown_rd;

   assign rd_index   = ctrl_req.addr[CTRL_ADDR_WIDTH-1:4];
   assign unknown_rd = !(rd_index inside {REG_CONTROL, REG_MOVE_INDEX, REG_POSITION,
                                          REG_HALF_MOVE, REG_QUIESCENCE, REG_MOVE_POSITION,
                                          REG_MOVE_EVAL, REG_MOVE_COUNT, REG_ROOT_EVAL,
                                          REG_MOVE_UCI, REG_TRANS_STATUS, REG_TRANS_EVAL,
                                          REG_TRANS_CMD, REG_TRANS_ARG});

   upper_zero : assert property (@(posedge clk) ctrl_dout[CTRL_DATA_WIDTH-1:32] == '0)
      else $error("ctrl_dout bits above 31 are set");

   unknown_reads_zero : assert property (@(posedge clk) disable iff (reset)
      unknown_rd |=> ctrl_dout == '0)
      else $error("unknown read index gave a nonzero ctrl_dout");

   board_held : assert property (@(posedge clk) disable iff (reset)
      !ctrl_req.en |=> $stable(board))
      else $error("board changed after a cycle with en low");

endmodule

bind numbat_control numbat_control_assertions u_assertions (
   .clk       (clk),
   .reset     (reset),
   .ctrl_req  (ctrl_req),
   .ctrl_dout (ctrl_dout),
   .board     (board)
);

//--- testbench/tb_numbat_control.sv
//**********************************************************
// Table-driven testbench for the host register block. Each
// row writes, reads or checks an engine-side output.
//**********************************************************
`timescale 1ns/1ps

module tb_numbat_control;

   import numbat_ctrl_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int MG_BITS      = $bits(movegen_status_t);
   localparam int RS_BITS      = $bits(root_status_t);
   localparam int TS_BITS      = $bits(trans_status_t);
   localparam int OP_WR        = 0;
   localparam int OP_RD        = 1;
   localparam int OP_SCMD      = 2;
   localparam int OP_TCMD      = 3;
   localparam int OP_BOARD_LO  = 4;
   localparam int OP_BOARD_HI  = 5;

   typedef struct {
      string        name;
      int           op;
      logic [13:0]  index;
      logic [15:0]  we;
      logic [127:0] din;
      logic [127:0] expected;
   } row_t;

   logic                 clk;
   logic                 reset;
   ctrl_req_t            ctrl_req;
   movegen_status_t      movegen_status;
   root_status_t         root_status;
   trans_status_t        trans_status;
   logic [127:0]         ctrl_dout;
   board_t               board;
   search_cmd_t          search_cmd;
   trans_cmd_t           trans_cmd;
   row_t                 rows[$];
   board_t               shadow_board; // expected board contents
   logic                 table_ready = 1'b0;
   int                   check_count;
   int                   error_count;

   numbat_control u_dut (
      .clk            (clk),
      .reset          (reset),
      .ctrl_req       (ctrl_req),
      .movegen_status (movegen_status),
      .root_status    (root_status),
      .trans_status   (trans_status),
      .ctrl_dout      (ctrl_dout),
      .board          (board),
      .search_cmd     (search_cmd),
      .trans_cmd      (trans_cmd)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] sign_extend(input logic signed [EVAL_WIDTH-1:0] eval);
      return 32'(eval);
   endfunction

   function automatic logic [31:0] uci_word(input logic [UCI_WIDTH-1:0] uci);
      logic [31:0] w;
      w = '0;
      w[19:16] = uci[15:12];
      for (int f = 0; f < 4; f++)
         w[4 * f +: 3] = uci[3 * f +: 3]; // 3-bit fields, gap bit above each
      return w;
   endfunction

   function automatic logic [31:0] status_bits();
      logic [31:0] w;
      w = '0;
      w[2]  = movegen_status.moves_ready;
      w[3]  = movegen_status.move_ready;
      w[4]  = root_status.stalemate;
      w[5]  = root_status.mate;
      w[6]  = root_status.thrice_rep;
      w[7]  = movegen_status.idle;
      w[8]  = root_status.fifty_move;
      w[9]  = root_status.insufficient;
      w[10] = root_status.check;
      return w;
   endfunction

   function automatic logic [31:0] trans_status_word();
      logic [31:0] w;
      w = '0;
      w[19]    = trans_status.capture;
      w[18]    = trans_status.collision;
      w[17:10] = trans_status.depth;
      w[5:4]   = trans_status.flag;
      w[1]     = trans_status.entry_valid;
      w[0]     = trans_status.idle;
      return w;
   endfunction

   task automatic add_row(input string name, input int op, input logic [13:0] index,
                          input logic [15:0] we, input logic [127:0] din,
                          input logic [127:0] expected);
      rows.push_back('{name, op, index, we, din, expected});
   endtask

   task automatic write_board(input string name, input logic hi, input logic [15:0] we);
      logic [127:0] word;
      word = {$urandom, $urandom, $urandom, $urandom};
      for (int lane = 0; lane < 16; lane++)
         if (we[lane])
            shadow_board[(hi ? 128 : 0) + lane * 8 +: 8] = word[lane * 8 +: 8];
      add_row(name, OP_WR, hi ? REG_BOARD_HI : REG_BOARD_LO, we, word, '0);
      add_row({name, " lo"}, OP_BOARD_LO, '0, '0, '0, shadow_board[127:0]);
      add_row({name, " hi"}, OP_BOARD_HI, '0, '0, '0, shadow_board[255:128]);
   endtask

   task automatic build_table();
      search_cmd_t scmd;
      trans_cmd_t  tcmd;
      logic [15:0] partial;
      scmd = '0;
      scmd.new_board_valid = 1'b1;
      scmd.clear_moves     = 1'b1;
      scmd.quiescence      = 1'b1;
      scmd.soft_reset      = 1'b1;
      scmd.move_index      = 7'h5A;
      scmd.half_move       = 7'h33;
      scmd.position        = position_t'(9'h1A5);
      tcmd = '0;
      tcmd.depth   = 8'hA5;
      tcmd.clear   = 1'b1;
      tcmd.flag    = 2'b01;
      tcmd.store   = 1'b1;
      tcmd.capture = 1'b1;
      tcmd.eval    = 24'hF01234;
      add_row("reset search_cmd", OP_SCMD, '0, '0, '0, '0);
      add_row("reset trans_cmd", OP_TCMD, '0, '0, '0, '0);
      add_row("reset board lo", OP_BOARD_LO, '0, '0, '0, '0);
      add_row("reset board hi", OP_BOARD_HI, '0, '0, '0, '0);
      add_row("reset rd control", OP_RD, REG_CONTROL, '0, '0, 128'(status_bits()));
      // junk in the ignored bits of each word
      add_row("wr control", OP_WR, REG_CONTROL, 16'hFFFF, 128'h8000_00F3, '0);
      add_row("wr move index", OP_WR, REG_MOVE_INDEX, 16'h000F, 128'hFFFF_FFDA, '0);
      add_row("wr position", OP_WR, REG_POSITION, 16'h000F, 128'hABCD_E1A5, '0);
      add_row("wr half move", OP_WR, REG_HALF_MOVE, 16'h000F, 128'h0000_0033, '0);
      add_row("wr quiescence", OP_WR, REG_QUIESCENCE, 16'h0001, 128'h0000_0001, '0);
      add_row("search_cmd fields", OP_SCMD, '0, '0, '0, 128'(scmd));
      add_row("rd control", OP_RD, REG_CONTROL, '0, '0,
              128'(status_bits() | 32'h8000_0003));
      add_row("rd move index", OP_RD, REG_MOVE_INDEX, '0, '0, 128'h5A);
      add_row("rd position", OP_RD, REG_POSITION, '0, '0, 128'h1A5);
      add_row("rd half move", OP_RD, REG_HALF_MOVE, '0, '0, 128'h33);
      add_row("rd quiescence", OP_RD, REG_QUIESCENCE, '0, '0, 128'h1);
      write_board("wr board lo full", 1'b0, 16'hFFFF);
      write_board("wr board hi full", 1'b1, 16'hFFFF);
      partial = 16'($urandom) & 16'h7FFE | 16'h0001; // never empty, never full
      write_board("wr board lo part", 1'b0, partial);
      partial = 16'($urandom) & 16'h7FFE | 16'h0001;
      write_board("wr board hi part", 1'b1, partial);
      add_row("wr trans cmd", OP_WR, REG_TRANS_CMD, 16'h000F, 128'hFFFF_A5E6, '0);
      add_row("wr trans arg", OP_WR, REG_TRANS_ARG, 16'h000F, 128'hC5F0_1234, '0);
      add_row("trans_cmd fields", OP_TCMD, '0, '0, '0, 128'(tcmd));
      add_row("rd trans cmd", OP_RD, REG_TRANS_CMD, '0, '0, 128'h0000_A526);
      add_row("rd trans arg", OP_RD, REG_TRANS_ARG, '0, '0, 128'h80F0_1234);
      // inverted command bits, so hash_only and lookup also go high
      tcmd.depth     = 8'h5A;
      tcmd.clear     = 1'b0;
      tcmd.hash_only = 1'b1;
      tcmd.flag      = 2'b10;
      tcmd.store     = 1'b0;
      tcmd.lookup    = 1'b1;
      add_row("wr trans cmd alt", OP_WR, REG_TRANS_CMD, 16'h000F, 128'h0000_5AD9, '0);
      add_row("trans_cmd alt fields", OP_TCMD, '0, '0, '0, 128'(tcmd));
      add_row("rd trans cmd alt", OP_RD, REG_TRANS_CMD, '0, '0, 128'h0000_5A19);
      add_row("rd move uci", OP_RD, REG_MOVE_UCI, '0, '0, 128'(uci_word(movegen_status.uci)));
      add_row("rd move eval", OP_RD, REG_MOVE_EVAL, '0, '0,
              128'(sign_extend(movegen_status.eval)));
      add_row("rd root eval", OP_RD, REG_ROOT_EVAL, '0, '0, 128'(sign_extend(root_status.eval)));
      add_row("rd move count", OP_RD, REG_MOVE_COUNT, '0, '0, 128'(movegen_status.move_count));
      add_row("rd move position", OP_RD, REG_MOVE_POSITION, '0, '0,
              128'(movegen_status.position));
      add_row("rd trans status", OP_RD, REG_TRANS_STATUS, '0, '0, 128'(trans_status_word()));
      add_row("rd trans eval", OP_RD, REG_TRANS_EVAL, '0, '0,
              128'(sign_extend(trans_status.eval)));
      add_row("rd unknown 77", OP_RD, 14'd77, '0, '0, '0);
      add_row("rd unknown top", OP_RD, 14'h3FFF, '0, '0, '0);
   endtask

   task automatic check_value(input string what, input logic [127:0] actual,
                              input logic [127:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Error at %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic run_row(input row_t r);
      ctrl_req_t req;
      int        errors_before;
      errors_before = error_count;
      req.en   = (r.op == OP_WR || r.op == OP_RD);
      req.we   = (r.op == OP_WR) ? r.we : '0;
      req.addr = {r.index, 4'h0};
      req.din  = r.din;
      @(posedge clk);
      ctrl_req <= req;
      @(posedge clk);
      ctrl_req.en <= 1'b0; // access done, back to idle
      ctrl_req.we <= '0;
      @(negedge clk);
      case (r.op)
         OP_RD       : check_value(r.name, ctrl_dout, r.expected);
         OP_SCMD     : check_value(r.name, 128'(search_cmd), r.expected);
         OP_TCMD     : check_value(r.name, 128'(trans_cmd), r.expected);
         OP_BOARD_LO : check_value(r.name, board[127:0], r.expected);
         OP_BOARD_HI : check_value(r.name, board[255:128], r.expected);
         default     : ;
      endcase
      $display("%s: %s", r.name, (error_count == errors_before) ? "ok" : "mismatch");
   endtask

   initial
   begin
      void'($urandom(32'h7a8a680c));
      reset          = 1'b1;
      ctrl_req       = '0;
      movegen_status = MG_BITS'({$urandom, $urandom});
      root_status    = RS_BITS'($urandom);
      trans_status   = TS_BITS'({$urandom, $urandom});
      movegen_status.eval[EVAL_WIDTH-1] = 1'b1; // negative
      root_status.eval[EVAL_WIDTH-1]    = 1'b0;
      trans_status.eval[EVAL_WIDTH-1]   = 1'b1;
      check_count  = 0;
      error_count  = 0;
      shadow_board = '0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      foreach (rows[i])
         run_row(rows[i]);
      @(posedge clk);
      $display("%0d rows, %0d checks, %0d errors", rows.size(), check_count, error_count);
      if (error_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      wait (table_ready);
      repeat (rows.size() * 4 + RESET_CYCLES) @(posedge clk);
      $display("Watchdog expired before all table rows were run");
      $display("Test failed");
      $finish;
   end

endmodule

//--- filelist.f
src/numbat_ctrl_pkg.sv
src/board_load_regs.sv
src/search_ctrl_regs.sv
src/status_read_mux.sv
src/numbat_control.sv
testbench/numbat_control_assertions.sv
testbench/tb_numbat_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the register block testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_numbat_control -f filelist.f; then
   echo "Verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/Vtb_numbat_control)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Test passed$" <<< "$sim_output"; then
   exit 0
fi
exit 1
